//--- bsg_link_settings.svh
// link hub sizing
// widths and depths for one logical link

`ifndef BSG_LINK_SETTINGS_SVH
`define BSG_LINK_SETTINGS_SVH

////////////////////////////////////////////////////////////
// pad channel
////////////////////////////////////////////////////////////

// bits per pad word
`define BSG_LINK_CHANNEL_WIDTH 16

////////////////////////////////////////////////////////////
// flow control
////////////////////////////////////////////////////////////

// log2 of receive fifo entries
// also the sender's credits out of reset
`define BSG_LINK_LG_FIFO_DEPTH 3

// log2 of dequeues per returned token
// one token is worth this many credits
`define BSG_LINK_LG_TOKEN_DECIMATION 1

`endif

//--- source/bsg_link_pkg.sv
// link hub types

`default_nettype none

`include "bsg_link_settings.svh"

package bsg_link_pkg;

  ////////////////////////////////////////////////////////////
  // widths with a meaning
  ////////////////////////////////////////////////////////////

  // one channel word
  typedef logic [`BSG_LINK_CHANNEL_WIDTH-1:0] link_data_t;

  // credit count, one extra bit so the full depth fits
  typedef logic [`BSG_LINK_LG_FIFO_DEPTH:0] credit_cnt_t;

  // receive fifo address
  typedef logic [`BSG_LINK_LG_FIFO_DEPTH-1:0] fifo_ptr_t;

  // dequeue counter between tokens
  typedef logic [`BSG_LINK_LG_TOKEN_DECIMATION-1:0] token_cnt_t;

  ////////////////////////////////////////////////////////////
  // pad word
  ////////////////////////////////////////////////////////////

  // valid strobe plus data, as seen on the pads
  // v is sampled every cycle, no stall on this side
  typedef struct packed {
    logic       v;
    link_data_t data;
  } link_pad_s;

endpackage

`default_nettype wire

//--- source/bsg_link_fifo.sv
// link receive fifo
// circular buffer with wrap bits

`timescale 1ns/100ps
`default_nettype none

`include "bsg_link_settings.svh"

module bsg_link_fifo
(
  input  logic                     core_clk_i,
  input  logic                     rst_n_i,
  // write side
  input  logic                     enq_i,
  input  bsg_link_pkg::link_data_t enq_data_i,
  // read side
  input  logic                     deq_i,
  output bsg_link_pkg::link_data_t head_data_o,
  output logic                     not_empty_o
);

  localparam int unsigned depth_lp = 1 << `BSG_LINK_LG_FIFO_DEPTH;

  bsg_link_pkg::link_data_t  mem_r [depth_lp];
  bsg_link_pkg::fifo_ptr_t   wr_ptr_r;
  bsg_link_pkg::fifo_ptr_t   rd_ptr_r;
  logic                      wr_wrap_r;
  logic                      rd_wrap_r;

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  // no full check here, sender credits bound the occupancy
  always_ff @(posedge core_clk_i)
  begin
    if (enq_i)
    begin
      mem_r[wr_ptr_r] <= enq_data_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // pointers
  ////////////////////////////////////////////////////////////

  // enq and deq are independent, both may fire together
  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r  <= '0;
      rd_ptr_r  <= '0;
      wr_wrap_r <= 1'b0;
      rd_wrap_r <= 1'b0;
    end
    else
    begin
      if (enq_i)
      begin
        wr_ptr_r <= wr_ptr_r + bsg_link_pkg::fifo_ptr_t'(1);
        // flip on the last slot
        if (wr_ptr_r == '1)
        begin
          wr_wrap_r <= ~wr_wrap_r;
        end
      end
      if (deq_i)
      begin
        rd_ptr_r <= rd_ptr_r + bsg_link_pkg::fifo_ptr_t'(1);
        if (rd_ptr_r == '1)
        begin
          rd_wrap_r <= ~rd_wrap_r;
        end
      end
    end
  end

  // equal pointers and equal wraps is empty
  // equal pointers with wraps apart is full, still not empty
  assign not_empty_o = (wr_ptr_r != rd_ptr_r) | (wr_wrap_r != rd_wrap_r);

  // head is read straight from the array
  assign head_data_o = mem_r[rd_ptr_r];

endmodule

`default_nettype wire

//--- source/bsg_link_upstream.sv
// link upstream half
// credit-based sender onto the pad

`timescale 1ns/100ps
`default_nettype none

`include "bsg_link_settings.svh"

module bsg_link_upstream
(
  input  logic                     core_clk_i,
  input  logic                     rst_n_i,
  // core side, level valid with ready
  input  logic                     core_v_i,
  input  bsg_link_pkg::link_data_t core_data_i,
  output logic                     core_ready_o,
  // pad side
  output bsg_link_pkg::link_pad_s  link_o,
  input  logic                     link_token_i
);

  // start with one credit per receive fifo entry
  localparam bsg_link_pkg::credit_cnt_t credit_init_lp =
    bsg_link_pkg::credit_cnt_t'(1 << `BSG_LINK_LG_FIFO_DEPTH);

  // credits regained per token pulse
  localparam bsg_link_pkg::credit_cnt_t token_credits_lp =
    bsg_link_pkg::credit_cnt_t'(1 << `BSG_LINK_LG_TOKEN_DECIMATION);

  bsg_link_pkg::credit_cnt_t credit_cnt_r;
  bsg_link_pkg::credit_cnt_t credit_cnt_n;
  logic                      link_v_r;
  bsg_link_pkg::link_data_t  link_data_r;
  logic                      send;

  ////////////////////////////////////////////////////////////
  // credit handshake
  ////////////////////////////////////////////////////////////

  // any credit left means the far fifo has room
  assign core_ready_o = (credit_cnt_r != '0);
  assign send         = core_v_i & core_ready_o;

  // spend and regain can land on the same edge
  always_comb
  begin
    credit_cnt_n = credit_cnt_r;
    if (send)
    begin
      credit_cnt_n = credit_cnt_n - bsg_link_pkg::credit_cnt_t'(1);
    end
    if (link_token_i)
    begin
      credit_cnt_n = credit_cnt_n + token_credits_lp;
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      credit_cnt_r <= credit_init_lp;
      link_v_r     <= 1'b0;
    end
    else
    begin
      credit_cnt_r <= credit_cnt_n;
      // strobe is high for exactly the cycle after an accept
      link_v_r     <= send;
    end
  end

  ////////////////////////////////////////////////////////////
  // pad output register
  ////////////////////////////////////////////////////////////

  // payload only loads on accept
  always_ff @(posedge core_clk_i)
  begin
    if (send)
    begin
      link_data_r <= core_data_i;
    end
  end

  assign link_o = '{v: link_v_r, data: link_data_r};

endmodule

`default_nettype wire

//--- source/bsg_link_downstream.sv
// link downstream half
// pad capture, receive buffer and token return

`timescale 1ns/100ps
`default_nettype none

module bsg_link_downstream
(
  input  logic                     core_clk_i,
  input  logic                     rst_n_i,
  // pad side
  input  bsg_link_pkg::link_pad_s  link_i,
  output logic                     link_token_o,
  // core side, valid with yumi
  output logic                     core_v_o,
  output bsg_link_pkg::link_data_t core_data_o,
  input  logic                     core_yumi_i
);

  logic                      link_v_r;
  bsg_link_pkg::link_data_t  link_data_r;
  bsg_link_pkg::token_cnt_t  deq_cnt_r;
  logic                      token_r;
  logic                      group_done;

  ////////////////////////////////////////////////////////////
  // pad capture
  ////////////////////////////////////////////////////////////

  // flop the pad word before it reaches the buffer
  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      link_v_r <= 1'b0;
    end
    else
    begin
      link_v_r <= link_i.v;
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    link_data_r <= link_i.data;
  end

  // one write per captured valid, head goes to the core as is
  bsg_link_fifo fifo_i
  (.core_clk_i  (core_clk_i )
  ,.rst_n_i     (rst_n_i    )
  ,.enq_i       (link_v_r   )
  ,.enq_data_i  (link_data_r)
  ,.deq_i       (core_yumi_i)
  ,.head_data_o (core_data_o)
  ,.not_empty_o (core_v_o   )
  );

  ////////////////////////////////////////////////////////////
  // token decimation
  ////////////////////////////////////////////////////////////

  // last dequeue of a group
  assign group_done = core_yumi_i & (deq_cnt_r == '1);

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      deq_cnt_r <= '0;
      token_r   <= 1'b0;
    end
    else
    begin
      if (core_yumi_i)
      begin
        // wraps back to zero after the last of the group
        deq_cnt_r <= deq_cnt_r + bsg_link_pkg::token_cnt_t'(1);
      end
      // single cycle pulse
      token_r <= group_done;
    end
  end

  assign link_token_o = token_r;

endmodule

`default_nettype wire

//--- source/bsg_chip_link_hub.sv
// chip link hub
// one logical link, send and receive halves

`timescale 1ns/100ps
`default_nettype none

module bsg_chip_link_hub
(
  input  logic                     core_clk_i,
  input  logic                     rst_n_i,

  ////////////////////////////////////////////////////////////
  // core side
  ////////////////////////////////////////////////////////////

  // words going out
  input  logic                     core_v_i,
  input  bsg_link_pkg::link_data_t core_data_i,
  output logic                     core_ready_o,

  // words coming in
  output logic                     core_v_o,
  output bsg_link_pkg::link_data_t core_data_o,
  input  logic                     core_yumi_i,

  ////////////////////////////////////////////////////////////
  // pad side
  ////////////////////////////////////////////////////////////

  // outgoing channel and its returned tokens
  output bsg_link_pkg::link_pad_s  link_o,
  input  logic                     link_token_i,

  // incoming channel and the tokens we send back
  input  bsg_link_pkg::link_pad_s  link_i,
  output logic                     link_token_o
);

  // sender half
  // owns the credit counter and the pad output flop
  bsg_link_upstream upstream_i
  (.core_clk_i   (core_clk_i  )
  ,.rst_n_i      (rst_n_i     )
  ,.core_v_i     (core_v_i    )
  ,.core_data_i  (core_data_i )
  ,.core_ready_o (core_ready_o)
  ,.link_o       (link_o      )
  ,.link_token_i (link_token_i)
  );

  // receiver half
  // buffers pad words and hands back tokens
  bsg_link_downstream downstream_i
  (.core_clk_i   (core_clk_i  )
  ,.rst_n_i      (rst_n_i     )
  ,.link_i       (link_i      )
  ,.link_token_o (link_token_o)
  ,.core_v_o     (core_v_o    )
  ,.core_data_o  (core_data_o )
  ,.core_yumi_i  (core_yumi_i )
  );

endmodule

`default_nettype wire

//--- test/link_checker.sv
// link hub checker
// scoreboard on the core and pad ports

`timescale 1ns/100ps
`default_nettype none

`include "bsg_link_settings.svh"

module link_checker
(
  input  logic                     core_clk_i,
  input  logic                     rst_n_i,
  // send side of the dut
  input  logic                     send_v_i,
  input  bsg_link_pkg::link_data_t send_data_i,
  input  logic                     send_ready_i,
  // receive side of the dut
  input  logic                     recv_v_i,
  input  bsg_link_pkg::link_data_t recv_data_i,
  input  logic                     recv_yumi_i,
  // outgoing pad word and returned token
  input  bsg_link_pkg::link_pad_s  link_i,
  input  logic                     token_i,
  // phase flags from the stimulus
  input  logic                     stall_i,
  input  logic                     end_i,
  output int                       err_cnt_o,
  output int                       acc_cnt_o,
  output int                       deq_cnt_o,
  output int                       token_cnt_o
);

  // credits the sender owns after reset
  localparam int credit_total_lp = 1 << `BSG_LINK_LG_FIFO_DEPTH;

  bsg_link_pkg::link_data_t sent_q [$];
  int   err_cnt   = 0;
  int   deq_cnt   = 0;
  int   token_cnt = 0;
  int   stall_acc = 0;
  logic rst_q     = 1'b0;
  logic stall_q   = 1'b0;
  logic dropped   = 1'b0;
  logic end_done  = 1'b0;

  // reference model keeps accept order since the link is a fifo
  function automatic bsg_link_pkg::link_data_t expected_word(input int n);
    return sent_q[n];
  endfunction

  // wrong value
  task automatic report_fail(input string msg);
    err_cnt++;
    $display("Fail %0t: %s", $time, msg);
  endtask

  // protocol or bookkeeping problem
  task automatic report_error(input string msg);
    err_cnt++;
    $display("error at %0t: %s", $time, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // sampled at the rising edge with pre-edge values
  ////////////////////////////////////////////////////////////

  always @(posedge core_clk_i)
  begin
    if (rst_n_i)
    begin
      // everything idle in the first cycle out of reset
      if (!rst_q)
      begin
        if (link_i.v !== 1'b0 || token_i !== 1'b0 || recv_v_i !== 1'b0
            || send_ready_i !== 1'b1)
        begin
          report_fail($sformatf("reset state v=%b token=%b core_v=%b ready=%b",
                                link_i.v, token_i, recv_v_i, send_ready_i));
        end
      end
      // back-pressure window opens
      if (stall_i && !stall_q)
      begin
        stall_acc = 0;
        dropped   = 1'b0;
      end
      if (send_v_i && send_ready_i)
      begin
        sent_q.push_back(send_data_i);
        if (stall_i)
        begin
          stall_acc++;
        end
      end
      if (stall_i)
      begin
        if (!send_ready_i)
        begin
          dropped = 1'b1;
        end
        else if (dropped)
        begin
          report_fail("core_ready_o rose again with no consumer");
        end
      end
      // credit limit must have been hit exactly once the window closes
      if (!stall_i && stall_q)
      begin
        if (!dropped)
        begin
          report_error("core_ready_o never dropped under back-pressure");
        end
        if (stall_acc != credit_total_lp)
        begin
          report_fail($sformatf("%0d words accepted under back-pressure, expected %0d",
                                stall_acc, credit_total_lp));
        end
      end
      // dequeue against the nth accepted word
      if (recv_yumi_i)
      begin
        if (deq_cnt >= sent_q.size())
        begin
          report_error($sformatf("dequeue %0d with no word accepted behind it", deq_cnt));
        end
        else if (recv_data_i !== expected_word(deq_cnt))
        begin
          report_fail($sformatf("word %0d got %h expected %h",
                                deq_cnt, recv_data_i, expected_word(deq_cnt)));
        end
        deq_cnt++;
      end
      if (token_i)
      begin
        token_cnt++;
      end
      // totals and token decimation after the drain
      if (end_i && !end_done)
      begin
        end_done = 1'b1;
        if (deq_cnt != sent_q.size())
        begin
          report_fail($sformatf("dequeued %0d of %0d accepted", deq_cnt, sent_q.size()));
        end
        if (token_cnt != (deq_cnt >> `BSG_LINK_LG_TOKEN_DECIMATION))
        begin
          report_fail($sformatf("%0d tokens for %0d dequeues", token_cnt, deq_cnt));
        end
        if (recv_v_i)
        begin
          report_error("receive fifo still holds words after the drain");
        end
      end
    end
    rst_q   = rst_n_i;
    stall_q = stall_i;
    // counters for the testbench settle after the edge
    err_cnt_o   <= err_cnt;
    acc_cnt_o   <= sent_q.size();
    deq_cnt_o   <= deq_cnt;
    token_cnt_o <= token_cnt;
  end

endmodule

`default_nettype wire

//--- test/tb_bsg_chip_link_hub.sv
// link hub testbench
// pads looped back, core side driven and consumed

`timescale 1ns/100ps
`default_nettype none

`include "bsg_link_settings.svh"

module tb_bsg_chip_link_hub;

  localparam int num_words_lp    = 200;
  localparam int phase1_words_lp = 40;
  localparam int hold_cycles_lp  = 20;
  // roughly 20 cycles a word plus slack for the stall
  localparam int timeout_lp      = num_words_lp * 20 + 1000;

  // consumer modes
  localparam int mode_consume_lp = 0;
  localparam int mode_hold_lp    = 1;
  localparam int mode_random_lp  = 2;

  logic                     clk        = 1'b0;
  logic                     rst_n      = 1'b0;
  logic                     send_v     = 1'b0;
  bsg_link_pkg::link_data_t send_data  = '0;
  logic                     send_ready;
  logic                     recv_v;
  bsg_link_pkg::link_data_t recv_data;
  logic                     recv_yumi;
  logic                     yumi_en    = 1'b0;
  bsg_link_pkg::link_pad_s  link_pad;
  logic                     link_token;
  logic                     stall      = 1'b0;
  logic                     end_check  = 1'b0;
  int                       send_limit = 0;
  int                       yumi_mode  = mode_consume_lp;
  int                       sent_cnt   = 0;
  int                       sent_next;
  int                       cycle_cnt  = 0;
  int                       seed       = 32'h0e227441;
  logic                     accepted;
  logic [31:0]              rnd;
  int                       err_cnt;
  int                       acc_cnt;
  int                       deq_cnt;
  int                       token_cnt;

  always #5 clk = ~clk;

  // yumi only ever rides on a valid head
  assign recv_yumi = yumi_en & recv_v;

  // pads looped back onto the same hub
  bsg_chip_link_hub bsg_chip_link_hub_i
  (.core_clk_i   (clk       )
  ,.rst_n_i      (rst_n     )
  ,.core_v_i     (send_v    )
  ,.core_data_i  (send_data )
  ,.core_ready_o (send_ready)
  ,.core_v_o     (recv_v    )
  ,.core_data_o  (recv_data )
  ,.core_yumi_i  (recv_yumi )
  ,.link_o       (link_pad  )
  ,.link_token_i (link_token)
  ,.link_i       (link_pad  )
  ,.link_token_o (link_token)
  );

  link_checker checker_i
  (.core_clk_i   (clk       )
  ,.rst_n_i      (rst_n     )
  ,.send_v_i     (send_v    )
  ,.send_data_i  (send_data )
  ,.send_ready_i (send_ready)
  ,.recv_v_i     (recv_v    )
  ,.recv_data_i  (recv_data )
  ,.recv_yumi_i  (recv_yumi )
  ,.link_i       (link_pad  )
  ,.token_i      (link_token)
  ,.stall_i      (stall     )
  ,.end_i        (end_check )
  ,.err_cnt_o    (err_cnt   )
  ,.acc_cnt_o    (acc_cnt   )
  ,.deq_cnt_o    (deq_cnt   )
  ,.token_cnt_o  (token_cnt )
  );

  ////////////////////////////////////////////////////////////
  // sender and consumer
  ////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      send_v  <= 1'b0;
      yumi_en <= 1'b0;
    end
    else
    begin
      // new word only once the old one is taken
      accepted  = send_v & send_ready;
      sent_next = sent_cnt + (accepted ? 1 : 0);
      sent_cnt  <= sent_next;
      send_v    <= (sent_next < send_limit);
      if (accepted)
      begin
        rnd = $random(seed);
        send_data <= rnd[`BSG_LINK_CHANNEL_WIDTH-1:0];
      end
      if (yumi_mode == mode_random_lp)
      begin
        rnd = $random(seed);
        yumi_en <= rnd[0];
      end
      else
      begin
        yumi_en <= (yumi_mode == mode_consume_lp);
      end
    end
  end

  task automatic print_counts();
    $display("errors %0d, accepted %0d, dequeued %0d, tokens %0d",
             err_cnt, acc_cnt, deq_cnt, token_cnt);
  endtask

  // all words out and all their tokens home
  task automatic wait_for_drain(input int n);
    while (deq_cnt < n || token_cnt < (n >> `BSG_LINK_LG_TOKEN_DECIMATION))
    begin
      @(posedge clk);
    end
    @(posedge clk);
  endtask

  task automatic wait_for_ready(input logic level);
    while (send_ready !== level)
    begin
      @(posedge clk);
    end
  endtask

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_lp)
    begin
      $display("timeout after %0d cycles, %0d of %0d words dequeued",
               cycle_cnt, deq_cnt, num_words_lp);
      print_counts();
      $display("TEST FAILED");
      $finish;
    end
  end

  initial
  begin
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    // steady stream, consumer always ready
    send_limit <= phase1_words_lp;
    wait_for_drain(phase1_words_lp);
    // back-pressure from an empty link
    yumi_mode  <= mode_hold_lp;
    stall      <= 1'b1;
    send_limit <= phase1_words_lp + 20;
    wait_for_ready(1'b0);
    repeat (hold_cycles_lp) @(posedge clk);
    // release, then random consumption to the end
    stall      <= 1'b0;
    yumi_mode  <= mode_random_lp;
    send_limit <= num_words_lp;
    wait_for_ready(1'b1);
    wait_for_drain(num_words_lp);
    end_check <= 1'b1;
    repeat (3) @(posedge clk);
    print_counts();
    if (err_cnt == 0 && deq_cnt == num_words_lp)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bsg_chip_link_hub.f
+incdir+.
source/bsg_link_pkg.sv
source/bsg_link_fifo.sv
source/bsg_link_upstream.sv
source/bsg_link_downstream.sv
source/bsg_chip_link_hub.sv
test/link_checker.sv
test/tb_bsg_chip_link_hub.sv

//--- Makefile
# Verilator build and run for the chip link hub

VERILATOR ?= verilator
TOP       := tb_bsg_chip_link_hub
FLIST     := bsg_chip_link_hub.f
VFLAGS    := --binary --timing --timescale 1ns/100ps
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SRCS := bsg_link_settings.svh \
        $(wildcard source/*.sv) \
        $(wildcard test/*.sv)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
	  echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "TEST PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
